// ==== hdl/heap_macros.svh ====
//--------------------------------------
// Sizes of the array heap. The array and
// index counts must be powers of two.
//--------------------------------------
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

// Bits in an array number
`define HEAP_ARRAY_BITS 2

// Bits in an element index
`define HEAP_INDEX_BITS 3

// Width of one element
`define HEAP_DATA_BITS 12

`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)   // Arrays in the pool
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)   // Capacity of one array

`endif

// ==== hdl/heapPkg.sv ====
//--------------------------------------
// Types shared by the heap blocks. The
// action codes follow the legacy numbering.
//--------------------------------------
`include "heap_macros.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNum_t;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex_t;  // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize_t;  // Size 0 to HEAP_LENGTH
  typedef logic [`HEAP_DATA_BITS-1:0]  dataWord_t;   // Element value

  // Operand seen as a size, for Resize
  typedef struct packed {
    logic [`HEAP_DATA_BITS-`HEAP_INDEX_BITS-2:0] spare;  // Must be zero
    arraySize_t                                  size;
  } sizeView_t;

  typedef union packed {
    dataWord_t data;      // Write, Push, Add
    sizeView_t sizeView;  // Resize
  } operandWord_u;

  typedef enum logic [4:0] {
    actReset  = 5'd1,
    actWrite  = 5'd2,
    actRead   = 5'd3,
    actSize   = 5'd4,
    actPush   = 5'd14,
    actPop    = 5'd15,
    actResize = 5'd17,
    actAlloc  = 5'd18,
    actFree   = 5'd19,
    actAdd    = 5'd20
  } heapAction_e;

  typedef enum logic [3:0] {
    stOk           = 4'd0,
    stNotAllocated = 4'd1,
    stOutOfBounds  = 4'd2,
    stFull         = 4'd3,
    stEmpty        = 4'd4,
    stTooLarge     = 4'd5,
    stNoMemory     = 4'd6,
    stBadAction    = 4'd7
  } heapStatus_e;

endpackage

// ==== hdl/heapAllocator.sv ====
//--------------------------------------
// Hands out array numbers. Freed arrays
// come back last-freed-first. Validity of
// a request is checked by the controller.
//--------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapAllocator (
  input  logic               clock,
  input  logic               reset,
  input  logic               allocate,
  input  logic               deallocate,
  input  logic               clear,
  input  heapPkg::arrayNum_t releaseArray,
  input  heapPkg::arrayNum_t array,
  output heapPkg::arrayNum_t allocHandle,
  output logic               allocAvailable,
  output logic               live
);
  import heapPkg::*;

  arrayNum_t                 freeStack [`HEAP_ARRAYS];  // Freed array numbers
  logic [`HEAP_ARRAY_BITS:0] stackDepth;                // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0] issuedCount;               // Arrays ever handed out
  logic [`HEAP_ARRAYS-1:0]   allocFlags;                // One per array
  arrayNum_t                 topSlot;
  arrayNum_t                 pushSlot;

  assign topSlot  = arrayNum_t'(stackDepth - 1'b1);
  assign pushSlot = stackDepth[`HEAP_ARRAY_BITS-1:0];  // Never full when pushing

  assign allocAvailable = (stackDepth != '0) || (issuedCount < `HEAP_ARRAYS);
  assign allocHandle    = (stackDepth != '0) ? freeStack[topSlot]
                                             : issuedCount[`HEAP_ARRAY_BITS-1:0];
  assign live           = allocFlags[array];

  //--------------------------------------
  // Control state
  //--------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      stackDepth  <= '0;
      issuedCount <= '0;
      allocFlags  <= '0;
    end else if (clear) begin
      stackDepth  <= '0;
      issuedCount <= '0;
      allocFlags  <= '0;
    end else if (allocate) begin
      if (stackDepth != '0) begin
        stackDepth <= stackDepth - 1'b1;   // Reuse a freed array
      end else begin
        issuedCount <= issuedCount + 1'b1;  // Fresh array
      end
      allocFlags[allocHandle] <= 1'b1;
    end else if (deallocate) begin
      stackDepth               <= stackDepth + 1'b1;
      allocFlags[releaseArray] <= 1'b0;
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (deallocate && !clear) begin
      freeStack[pushSlot] <= releaseArray;
    end
  end

endmodule

// ==== hdl/arraySizeTable.sv ====
//--------------------------------------
// Current size of every array. Sizes are
// written as given, without range checks.
//--------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module arraySizeTable (
  input  logic                clock,
  input  logic                reset,
  input  heapPkg::arrayNum_t  array,
  input  logic                sizeWrite,
  input  heapPkg::arrayNum_t  sizeArray,
  input  heapPkg::arraySize_t sizeValue,
  input  logic                clear,
  output heapPkg::arraySize_t currentSize
);
  import heapPkg::*;

  arraySize_t sizes [`HEAP_ARRAYS];  // One entry per array

  assign currentSize = sizes[array];  // Combinational lookup

  //--------------------------------------
  // Updates
  //--------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      sizes <= '{default: '0};
    end else if (clear) begin
      sizes <= '{default: '0};  // Allocator reset empties every array
    end else if (sizeWrite) begin
      sizes[sizeArray] <= sizeValue;
    end
  end

endmodule

// ==== hdl/elementStore.sv ====
//--------------------------------------
// Element memory for the whole pool.
// Contents are undefined until written.
//--------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module elementStore (
  input  logic                clock,
  input  logic                storeWrite,
  input  heapPkg::arrayNum_t  storeArray,
  input  heapPkg::elemIndex_t storeIndex,
  input  heapPkg::dataWord_t  storeData,
  output heapPkg::dataWord_t  storeRead
);
  import heapPkg::*;

  // One fixed block of HEAP_LENGTH words per array
  dataWord_t memory [`HEAP_ARRAYS][`HEAP_LENGTH];

  // Registered write, one word per cycle
  always_ff @(posedge clock) begin
    if (storeWrite) begin
      memory[storeArray][storeIndex] <= storeData;
    end
  end

  // Read sees the old word in a write cycle
  assign storeRead = memory[storeArray][storeIndex];

endmodule

// ==== hdl/heapController.sv ====
//--------------------------------------
// Decodes one request per cycle and checks
// it. Failed requests change no state and
// return 0 with their status code.
//--------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapController (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  request,
  input  heapPkg::heapAction_e  action,
  input  heapPkg::arrayNum_t    array,
  input  heapPkg::elemIndex_t   index,
  input  heapPkg::operandWord_u operand,
  input  heapPkg::arrayNum_t    allocHandle,
  input  logic                  allocAvailable,
  input  logic                  live,
  input  heapPkg::arraySize_t   currentSize,
  input  heapPkg::dataWord_t    storeRead,
  output logic                  allocate,
  output logic                  deallocate,
  output logic                  clear,
  output heapPkg::arrayNum_t    releaseArray,
  output logic                  sizeWrite,
  output heapPkg::arrayNum_t    sizeArray,
  output heapPkg::arraySize_t   sizeValue,
  output logic                  storeWrite,
  output heapPkg::arrayNum_t    storeArray,
  output heapPkg::elemIndex_t   storeIndex,
  output heapPkg::dataWord_t    storeData,
  output logic                  done,
  output heapPkg::dataWord_t    result,
  output heapPkg::heapStatus_e  status
);
  import heapPkg::*;

  arraySize_t  sizeUp;
  arraySize_t  sizeDown;
  arraySize_t  indexEnd;     // Size after a write at index
  logic        inBounds;
  logic        isFull;
  logic        isEmpty;
  logic        tooLarge;
  dataWord_t   nextResult;
  heapStatus_e nextStatus;

  assign sizeUp   = currentSize + arraySize_t'(1);
  assign sizeDown = currentSize - arraySize_t'(1);
  assign indexEnd = arraySize_t'(index) + arraySize_t'(1);
  assign inBounds = arraySize_t'(index) < currentSize;
  assign isFull   = currentSize >= arraySize_t'(`HEAP_LENGTH);
  assign isEmpty  = currentSize == '0;
  assign tooLarge = (|operand.sizeView.spare) ||
                    (operand.sizeView.size > arraySize_t'(`HEAP_LENGTH));

  assign releaseArray = array;
  assign storeArray   = array;
  assign storeData    = (action == actAdd) ? storeRead + operand.data : operand.data;

  // Element slot for each operation
  always_comb begin
    case (action)
      actPush: storeIndex = currentSize[`HEAP_INDEX_BITS-1:0];  // Slot past the end
      actPop:  storeIndex = sizeDown[`HEAP_INDEX_BITS-1:0];     // Last element
      default: storeIndex = index;
    endcase
  end

  //--------------------------------------
  // Decode and validity checks
  //--------------------------------------
  always_comb begin
    allocate   = 1'b0;
    deallocate = 1'b0;
    clear      = 1'b0;
    sizeWrite  = 1'b0;
    sizeArray  = array;
    sizeValue  = currentSize;
    storeWrite = 1'b0;
    nextResult = '0;
    nextStatus = stOk;
    if (request) begin
      case (action)
        actReset: clear = 1'b1;
        actAlloc: begin
          if (!allocAvailable) begin
            nextStatus = stNoMemory;
          end else begin
            allocate   = 1'b1;
            sizeWrite  = 1'b1;  // New array starts empty
            sizeArray  = allocHandle;
            sizeValue  = '0;
            nextResult = dataWord_t'(allocHandle);
          end
        end
        actFree, actWrite, actRead, actSize, actPush, actPop, actResize, actAdd: begin
          if (!live) begin
            nextStatus = stNotAllocated;
          end else begin
            case (action)
              actFree:  deallocate = 1'b1;
              actWrite: begin
                storeWrite = 1'b1;
                nextResult = operand.data;
                if (!inBounds) begin
                  sizeWrite = 1'b1;  // Extend to index plus one
                  sizeValue = indexEnd;
                end
              end
              actRead: begin
                if (!inBounds) nextStatus = stOutOfBounds;
                else nextResult = storeRead;
              end
              actSize: nextResult = dataWord_t'(currentSize);
              actPush: begin
                if (isFull) begin
                  nextStatus = stFull;
                end else begin
                  storeWrite = 1'b1;
                  sizeWrite  = 1'b1;
                  sizeValue  = sizeUp;
                end
              end
              actPop: begin
                if (isEmpty) begin
                  nextStatus = stEmpty;
                end else begin
                  sizeWrite  = 1'b1;
                  sizeValue  = sizeDown;
                  nextResult = storeRead;
                end
              end
              actResize: begin
                if (tooLarge) begin
                  nextStatus = stTooLarge;
                end else begin
                  sizeWrite = 1'b1;
                  sizeValue = operand.sizeView.size;
                end
              end
              actAdd: begin
                if (!inBounds) begin
                  nextStatus = stOutOfBounds;
                end else begin
                  storeWrite = 1'b1;
                  nextResult = storeData;  // New element value
                end
              end
            endcase
          end
        end
        default: nextStatus = stBadAction;  // Unsupported code
      endcase
    end
  end

  //--------------------------------------
  // Reply registers
  //--------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      done   <= 1'b0;
      result <= '0;
      status <= stOk;
    end else begin
      done <= request;  // One cycle after the request
      if (request) begin
        result <= nextResult;
        status <= nextStatus;  // Held until the next reply
      end
    end
  end

endmodule

// ==== hdl/heapTop.sv ====
//--------------------------------------
// Array heap unit. One request per clock,
// reply one cycle later, no back-pressure.
//--------------------------------------
`timescale 1ns/1ps

module heapTop (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  request,
  input  heapPkg::heapAction_e  action,
  input  heapPkg::arrayNum_t    array,
  input  heapPkg::elemIndex_t   index,
  input  heapPkg::operandWord_u operand,
  output logic                  done,
  output heapPkg::dataWord_t    result,
  output heapPkg::heapStatus_e  status
);
  import heapPkg::*;

  // Allocator links
  logic       allocate;
  logic       deallocate;
  logic       clear;
  arrayNum_t  releaseArray;
  arrayNum_t  allocHandle;
  logic       allocAvailable;
  logic       live;

  // Size table links
  logic       sizeWrite;
  arrayNum_t  sizeArray;
  arraySize_t sizeValue;
  arraySize_t currentSize;

  // Element store links
  logic       storeWrite;
  arrayNum_t  storeArray;
  elemIndex_t storeIndex;
  dataWord_t  storeData;
  dataWord_t  storeRead;

  heapController u_heapController (
    .clock, .reset, .request, .action, .array, .index, .operand,
    .allocHandle, .allocAvailable, .live, .currentSize, .storeRead,
    .allocate, .deallocate, .clear, .releaseArray,
    .sizeWrite, .sizeArray, .sizeValue,
    .storeWrite, .storeArray, .storeIndex, .storeData,
    .done, .result, .status
  );

  heapAllocator u_heapAllocator (
    .clock, .reset, .allocate, .deallocate, .clear, .releaseArray, .array,
    .allocHandle, .allocAvailable, .live
  );

  arraySizeTable u_arraySizeTable (
    .clock, .reset, .array, .sizeWrite, .sizeArray, .sizeValue, .clear,
    .currentSize
  );

  elementStore u_elementStore (
    .clock, .storeWrite, .storeArray, .storeIndex, .storeData, .storeRead
  );

endmodule

// ==== test/heap_chk.sv ====
//--------------------------------------
// Reply timing checks, bound to heapTop.
// Status checks use the internal live bit.
//--------------------------------------
`timescale 1ns/1ps

module heapChk (
  input logic                 clock,
  input logic                 reset,
  input logic                 request,
  input heapPkg::heapAction_e action,
  input logic                 live,
  input logic                 done,
  input heapPkg::heapStatus_e status
);
  import heapPkg::*;

  logic arrayOp;  // Needs an allocated array

  assign arrayOp = request && (action inside {actFree, actWrite, actRead, actSize,
                                               actPush, actPop, actResize, actAdd});

  replyFollows: assert property (@(posedge clock) disable iff (!reset)
    request |=> done)
    else $error("done missing one cycle after a request");

  replyOnlyAfterRequest: assert property (@(posedge clock) disable iff (!reset)
    done |-> $past(request))
    else $error("done without a request in the cycle before");

  quietInReset: assert property (@(posedge clock) !reset |-> !done)
    else $error("done high during reset");

  deadArrayFails: assert property (@(posedge clock) disable iff (!reset)
    arrayOp && !live |=> status != stOk)
    else $error("operation on an unallocated array reported ok");

endmodule

bind heapTop heapChk u_heapChk (
  .clock, .reset, .request, .action, .live, .done, .status
);

// ==== test/heapTb.sv ====
//--------------------------------------
// Testbench for the array heap. Element
// values never written are not compared.
//--------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapTb;
  import heapPkg::*;

  localparam int TimeoutCycles = 20;

  logic         clock;
  logic         reset;
  logic         request;
  heapAction_e  action;
  arrayNum_t    array;
  elemIndex_t   index;
  operandWord_u operand;
  logic         done;
  dataWord_t    result;
  heapStatus_e  status;

  // Reference model
  logic         modelAlloc [`HEAP_ARRAYS];
  int           modelSize [`HEAP_ARRAYS];
  dataWord_t    modelMem [`HEAP_ARRAYS][`HEAP_LENGTH];
  logic         modelKnown [`HEAP_ARRAYS][`HEAP_LENGTH];  // Element written at least once
  arrayNum_t    modelStack [$];                           // Freed arrays, last on top
  int           modelIssued;

  int           checkCount;
  int           errorCount;
  int           testErrors;
  int           seedValue;

  heapTop u_heapTop (
    .clock, .reset, .request, .action, .array, .index, .operand,
    .done, .result, .status
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  // Allocator reset keeps element contents
  task automatic clearModel();
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      modelAlloc[a] = 1'b0;
      modelSize[a]  = 0;
    end
    modelStack.delete();
    modelIssued = 0;
  endtask

  task automatic predict(input heapAction_e act, input arrayNum_t arr, input elemIndex_t idx,
      input dataWord_t value, output dataWord_t expResult, output heapStatus_e expStatus,
      output logic expKnown);
    int slot;
    expResult = '0;
    expStatus = stOk;
    expKnown  = 1'b1;
    if (act == actReset) begin
      clearModel();
    end else if (act == actAlloc) begin
      slot = -1;
      if (modelStack.size() != 0) begin
        slot = int'(modelStack.pop_back());  // Last freed comes back first
      end else if (modelIssued < `HEAP_ARRAYS) begin
        slot = modelIssued;
        modelIssued++;
      end
      if (slot < 0) begin
        expStatus = stNoMemory;
      end else begin
        modelAlloc[slot] = 1'b1;
        modelSize[slot]  = 0;
        expResult        = dataWord_t'(slot);
      end
    end else if (!modelAlloc[arr]) begin
      expStatus = stNotAllocated;
    end else begin
      case (act)
        actFree: begin
          modelAlloc[arr] = 1'b0;
          modelStack.push_back(arr);
        end
        actWrite: begin
          modelMem[arr][idx]   = value;
          modelKnown[arr][idx] = 1'b1;
          if (int'(idx) >= modelSize[arr]) modelSize[arr] = int'(idx) + 1;
          expResult = value;
        end
        actRead: begin
          if (int'(idx) >= modelSize[arr]) begin
            expStatus = stOutOfBounds;
          end else begin
            expResult = modelMem[arr][idx];
            expKnown  = modelKnown[arr][idx];
          end
        end
        actSize: expResult = dataWord_t'(modelSize[arr]);
        actPush: begin
          if (modelSize[arr] >= `HEAP_LENGTH) begin
            expStatus = stFull;
          end else begin
            slot                  = modelSize[arr];
            modelMem[arr][slot]   = value;
            modelKnown[arr][slot] = 1'b1;
            modelSize[arr]        = slot + 1;
          end
        end
        actPop: begin
          if (modelSize[arr] == 0) begin
            expStatus = stEmpty;
          end else begin
            slot           = modelSize[arr] - 1;
            modelSize[arr] = slot;
            expResult      = modelMem[arr][slot];
            expKnown       = modelKnown[arr][slot];
          end
        end
        actResize: begin
          if (int'(value) > `HEAP_LENGTH) expStatus = stTooLarge;
          else modelSize[arr] = int'(value);
        end
        actAdd: begin
          if (int'(idx) >= modelSize[arr]) begin
            expStatus = stOutOfBounds;
          end else begin
            modelMem[arr][idx] = modelMem[arr][idx] + value;  // Wraps at data width
            expResult          = modelMem[arr][idx];
            expKnown           = modelKnown[arr][idx];
          end
        end
        default: expStatus = stBadAction;
      endcase
    end
  endtask

  // One request, then wait for its reply and compare
  task automatic issue(input heapAction_e act, input arrayNum_t arr, input elemIndex_t idx,
      input dataWord_t value);
    dataWord_t   expResult;
    heapStatus_e expStatus;
    logic        expKnown;
    int          waited;
    predict(act, arr, idx, value, expResult, expStatus, expKnown);
    request      = 1'b1;
    action       = act;
    array        = arr;
    index        = idx;
    operand.data = value;
    @(negedge clock);
    request = 1'b0;
    waited  = 1;
    while (!done && waited < TimeoutCycles) begin
      @(negedge clock);
      waited++;
    end
    assert (done) else begin
      $display("Timeout: no done within %0d cycles of a %s request", TimeoutCycles, act.name());
      errorCount++;
    end
    if (!done) begin
      $display("RESULT: FAIL");
      $finish;
    end else begin
      checkCount++;
      assert (status === expStatus) else begin
        $display("** Error status: expected %h, got %h (%s array %0d index %0d)",
                 expStatus, status, act.name(), arr, idx);
        errorCount++;
      end
      if (expKnown) begin
        checkCount++;
        assert (result === expResult) else begin
          $display("** Error result: expected %h, got %h (%s array %0d index %0d)",
                   expResult, result, act.name(), arr, idx);
          errorCount++;
        end
      end
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clock);
  endtask

  task automatic reportTest(input string name);
    $display("Test %s: %0d errors", name, errorCount - testErrors);
    testErrors = errorCount;
  endtask

  task automatic runRandom(input int count);
    int          pick;
    heapAction_e act;
    dataWord_t   value;
    repeat (count) begin
      pick  = $urandom_range(0, 31);
      value = dataWord_t'($urandom);
      if (pick == 0) act = actReset;
      else if (pick < 6) act = actAlloc;
      else if (pick < 8) act = actFree;
      else if (pick < 12) act = actWrite;
      else if (pick < 16) act = actRead;
      else if (pick < 18) act = actSize;
      else if (pick < 22) act = actPush;
      else if (pick < 25) act = actPop;
      else if (pick < 28) begin
        act   = actResize;
        value = (pick == 27) ? dataWord_t'(12'h800)
                             : dataWord_t'($urandom_range(0, `HEAP_LENGTH + 2));
      end else act = actAdd;
      issue(act, arrayNum_t'($urandom), elemIndex_t'($urandom), value);
      if ($urandom_range(0, 1) == 1) idle($urandom_range(1, 2));  // Else back to back
    end
  endtask

  //--------------------------------------
  // Test sequence
  //--------------------------------------
  initial begin
    seedValue  = $urandom(99);
    reset      = 1'b0;
    request    = 1'b0;
    action     = actReset;
    array      = '0;
    index      = '0;
    operand    = '0;
    checkCount = 0;
    errorCount = 0;
    testErrors = 0;
    clearModel();
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      for (int i = 0; i < `HEAP_LENGTH; i++) begin
        modelMem[a][i]   = '0;
        modelKnown[a][i] = 1'b0;
      end
    end
    repeat (3) @(negedge clock);
    reset = 1'b1;
    @(negedge clock);

    // Reply registers come out of reset idle
    checkCount += 2;
    assert (status === stOk) else begin
      $display("** Error status after reset: expected %h, got %h", stOk, status);
      errorCount++;
    end
    assert (result === '0) else begin
      $display("** Error result after reset: expected %h, got %h", dataWord_t'(0), result);
      errorCount++;
    end

    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      issue(actSize, arrayNum_t'(a), '0, '0);
      issue(actRead, arrayNum_t'(a), '0, '0);
    end
    repeat (`HEAP_ARRAYS + 1) issue(actAlloc, '0, '0, '0);  // Last one runs out
    reportTest("1 reset and allocation order");

    issue(actFree, 2'd2, '0, '0);
    issue(actAlloc, '0, '0, '0);
    issue(actFree, 2'd2, '0, '0);
    issue(actFree, 2'd2, '0, '0);
    issue(actAlloc, '0, '0, '0);
    reportTest("2 free and reuse");

    issue(actWrite, 2'd1, 3'd4, dataWord_t'($urandom));
    issue(actSize, 2'd1, '0, '0);
    issue(actRead, 2'd1, 3'd5, '0);
    issue(actRead, 2'd1, 3'd7, '0);
    issue(actRead, 2'd1, 3'd4, '0);
    issue(actWrite, 2'd1, 3'd2, dataWord_t'($urandom));
    issue(actSize, 2'd1, '0, '0);
    issue(actRead, 2'd1, 3'd2, '0);
    issue(actAdd, 2'd1, 3'd4, dataWord_t'($urandom));
    issue(actAdd, 2'd1, 3'd6, dataWord_t'($urandom));
    reportTest("3 write extends size");

    repeat (`HEAP_LENGTH + 1) issue(actPush, 2'd0, '0, dataWord_t'($urandom));
    repeat (`HEAP_LENGTH + 1) issue(actPop, 2'd0, '0, '0);
    reportTest("4 push and pop");

    issue(actResize, 2'd3, '0, 12'd6);
    issue(actSize, 2'd3, '0, '0);
    issue(actResize, 2'd3, '0, 12'd9);
    issue(actSize, 2'd3, '0, '0);
    issue(actResize, 2'd3, '0, 12'd8);
    issue(actSize, 2'd3, '0, '0);
    issue(actResize, 2'd3, '0, 12'h800);  // Spare bits set
    issue(actSize, 2'd3, '0, '0);
    reportTest("5 resize");

    runRandom(400);
    reportTest("6 random mix");

    idle(2);
    $display("Tests: 6, checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/heapPkg.sv
hdl/heapAllocator.sv
hdl/arraySizeTable.sv
hdl/elementStore.sv
hdl/heapController.sv
hdl/heapTop.sv
test/heap_chk.sv
test/heapTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the heap testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module heapTb -Mdir obj_dir -o heapSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/heapSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "RESULT: FAIL" "$logFile"; then
  exit 1
fi
if ! grep -q "RESULT: PASS" "$logFile"; then
  echo "No pass line found in $logFile"
  exit 1
fi
exit 0
